// ==== files.f ====
controlPkg.sv
specialDecoder.sv
extDecoder.sv
immDecoder.sv
memAccessDecoder.sv
branchDecoder.sv
controller.sv
controllerTb.sv

// ==== runSim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f files.f --top-module controllerTb -o controllerSim \
    && ./obj_dir/controllerSim | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== controllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controllerTb
    import controlPkg::*;
();

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instruction;
    ctrlWord_t   ctrl;

    logic [15:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testErrors;
    int          testChecks;
    int          waitCount;

    controller UUT (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    always #20 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    //////////////////////////////////////////////////
    // random fill for don't-care fields
    //////////////////////////////////////////////////

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrBit()};
        end
        return v;
    endfunction

    // special opcode word with bits 21 and 6 held fixed
    function automatic logic [31:0] rType(logic [5:0] fn, logic bit21, logic bit6);
        logic [31:0] rnd;
        logic [31:0] w;
        rnd = randomBits(18);
        w = {opSpecial, rnd[17:14], bit21, rnd[13:0], bit6, fn};
        // keep clear of the nop word
        if (w == 32'd0) begin
            w[11] = 1'b1;
        end
        return w;
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op);
        logic [31:0] rnd;
        rnd = randomBits(26);
        return {op, rnd[25:0]};
    endfunction

    function automatic logic [31:0] regimm(logic [4:0] rt);
        logic [31:0] rnd;
        rnd = randomBits(21);
        return {opRegimm, rnd[20:16], rt, rnd[15:0]};
    endfunction

    function automatic logic [31:0] special2Word(logic [5:0] fn);
        logic [31:0] rnd;
        rnd = randomBits(20);
        return {opSpecial2, rnd[19:0], fn};
    endfunction

    // bit 9 held at the seh/seb select
    function automatic logic [31:0] special3Word(logic sel);
        logic [31:0] rnd;
        rnd = randomBits(25);
        return {opSpecial3, rnd[24:9], sel, rnd[8:0]};
    endfunction

    //////////////////////////////////////////////////
    // expected control words
    //////////////////////////////////////////////////

    function automatic ctrlWord_t idleWord();
        ctrlWord_t c;
        c = '0;
        c.jalSrc = 1'b1;
        c.aluOp = aluAdd;
        c.memSize = sizeWord;
        return c;
    endfunction

    function automatic ctrlWord_t rTypeExp(aluOp_e op, logic sft);
        ctrlWord_t c;
        c = idleWord();
        c.regDst = 1'b1;
        c.regWrite = 1'b1;
        c.memToReg = 1'b1;
        c.aluSft = sft;
        c.aluOp = op;
        return c;
    endfunction

    function automatic ctrlWord_t immExp(aluOp_e op, logic zext);
        ctrlWord_t c;
        c = idleWord();
        c.aluSrc = 1'b1;
        c.regWrite = 1'b1;
        c.memToReg = 1'b1;
        c.zeroSrc = zext;
        c.aluOp = op;
        return c;
    endfunction

    // loads write memory data back and stores write nothing
    function automatic ctrlWord_t memExp(logic load, memSize_e size);
        ctrlWord_t c;
        c = idleWord();
        c.aluSrc = 1'b1;
        c.memRead = load;
        c.regWrite = load;
        c.memWrite = ~load;
        c.memSize = size;
        return c;
    endfunction

    function automatic ctrlWord_t jumpExp(aluOp_e op, logic cond, logic link);
        ctrlWord_t c;
        c = idleWord();
        c.branch = 1'b1;
        c.jZeroSrc = cond;
        c.aluOp = op;
        if (link) begin
            c.jalSrc = 1'b0;
            c.regWrite = 1'b1;
            c.memToReg = 1'b1;
        end
        return c;
    endfunction

    //////////////////////////////////////////////////
    // drive and compare
    //////////////////////////////////////////////////

    task automatic compareField(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checkCount++;
        testChecks++;
        assert (got === exp) else begin
            $display("FAIL %0t ns ctrl.%s got %0h expected %0h (instruction %h)",
                     $time, name, got, exp, instruction);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic applyAndCheck(input logic [31:0] instr, input ctrlWord_t exp);
        @(posedge clk);
        instruction <= instr;
        // combinational ctrl has settled by the falling edge
        @(negedge clk);
        compareField("aluSrc", 8'(ctrl.aluSrc), 8'(exp.aluSrc));
        compareField("regDst", 8'(ctrl.regDst), 8'(exp.regDst));
        compareField("regWrite", 8'(ctrl.regWrite), 8'(exp.regWrite));
        compareField("memRead", 8'(ctrl.memRead), 8'(exp.memRead));
        compareField("memWrite", 8'(ctrl.memWrite), 8'(exp.memWrite));
        compareField("memToReg", 8'(ctrl.memToReg), 8'(exp.memToReg));
        compareField("aluSft", 8'(ctrl.aluSft), 8'(exp.aluSft));
        compareField("zeroSrc", 8'(ctrl.zeroSrc), 8'(exp.zeroSrc));
        compareField("branch", 8'(ctrl.branch), 8'(exp.branch));
        compareField("jalSrc", 8'(ctrl.jalSrc), 8'(exp.jalSrc));
        compareField("jZeroSrc", 8'(ctrl.jZeroSrc), 8'(exp.jZeroSrc));
        compareField("aluOp", 8'(ctrl.aluOp), 8'(exp.aluOp));
        compareField("memSize", 8'(ctrl.memSize), 8'(exp.memSize));
    endtask

    task automatic startTest();
        testErrors = 0;
        testChecks = 0;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s: %0d checks, %0d errors", testCount, name, testChecks, testErrors);
    endtask

    task automatic runAllTests();
        // r-type funct table, shift forms and rotate selects
        startTest();
        repeat (3) begin
            applyAndCheck(rType(fnSll, 1'b0, 1'b0), rTypeExp(aluSll, 1'b1));
            applyAndCheck(rType(fnSrl, 1'b0, 1'b0), rTypeExp(aluSrl, 1'b1));
            applyAndCheck(rType(fnSrl, 1'b1, 1'b0), rTypeExp(aluRotr, 1'b1));
            applyAndCheck(rType(fnSra, 1'b0, 1'b0), rTypeExp(aluSra, 1'b1));
            applyAndCheck(rType(fnSllv, 1'b0, 1'b0), rTypeExp(aluSll, 1'b0));
            applyAndCheck(rType(fnSrlv, 1'b0, 1'b0), rTypeExp(aluSrl, 1'b0));
            applyAndCheck(rType(fnSrlv, 1'b0, 1'b1), rTypeExp(aluRotr, 1'b0));
            applyAndCheck(rType(fnSrav, 1'b0, 1'b0), rTypeExp(aluSra, 1'b0));
            applyAndCheck(rType(fnAdd, 1'b0, 1'b0), rTypeExp(aluAdd, 1'b0));
            applyAndCheck(rType(fnAddu, 1'b0, 1'b0), rTypeExp(aluAddu, 1'b0));
            applyAndCheck(rType(fnSub, 1'b0, 1'b0), rTypeExp(aluSub, 1'b0));
            applyAndCheck(rType(fnAnd, 1'b0, 1'b0), rTypeExp(aluAnd, 1'b0));
            applyAndCheck(rType(fnOr, 1'b0, 1'b0), rTypeExp(aluOr, 1'b0));
            applyAndCheck(rType(fnXor, 1'b0, 1'b0), rTypeExp(aluXor, 1'b0));
            applyAndCheck(rType(fnNor, 1'b0, 1'b0), rTypeExp(aluNor, 1'b0));
            applyAndCheck(rType(fnSlt, 1'b0, 1'b0), rTypeExp(aluSlt, 1'b0));
            applyAndCheck(rType(fnSltu, 1'b0, 1'b0), rTypeExp(aluSltu, 1'b0));
            applyAndCheck(rType(fnMovz, 1'b0, 1'b0), rTypeExp(aluMovz, 1'b0));
            applyAndCheck(rType(fnMovn, 1'b0, 1'b0), rTypeExp(aluMovn, 1'b0));
        end
        finishTest("r-type");

        startTest();
        repeat (3) begin
            applyAndCheck(iType(opAddi), immExp(aluAdd, 1'b0));
            applyAndCheck(iType(opAddiu), immExp(aluAddu, 1'b0));
            applyAndCheck(iType(opSlti), immExp(aluSlt, 1'b0));
            applyAndCheck(iType(opSltiu), immExp(aluSltu, 1'b1));
            applyAndCheck(iType(opAndi), immExp(aluAnd, 1'b1));
            applyAndCheck(iType(opOri), immExp(aluOr, 1'b1));
            applyAndCheck(iType(opXori), immExp(aluXor, 1'b1));
            applyAndCheck(iType(opLui), immExp(aluLui, 1'b0));
        end
        finishTest("i-type");

        startTest();
        repeat (3) begin
            applyAndCheck(iType(opLw), memExp(1'b1, sizeWord));
            applyAndCheck(iType(opLh), memExp(1'b1, sizeHalf));
            applyAndCheck(iType(opLb), memExp(1'b1, sizeByte));
            applyAndCheck(iType(opSw), memExp(1'b0, sizeWord));
            applyAndCheck(iType(opSh), memExp(1'b0, sizeHalf));
            applyAndCheck(iType(opSb), memExp(1'b0, sizeByte));
        end
        finishTest("load/store");

        startTest();
        repeat (3) begin
            applyAndCheck(regimm(5'b00001), jumpExp(aluBgez, 1'b1, 1'b0));
            applyAndCheck(regimm(5'b00000), jumpExp(aluBltz, 1'b1, 1'b0));
            applyAndCheck(iType(opBeq), jumpExp(aluBeq, 1'b1, 1'b0));
            applyAndCheck(iType(opBne), jumpExp(aluBne, 1'b1, 1'b0));
            applyAndCheck(iType(opBgtz), jumpExp(aluBgtz, 1'b1, 1'b0));
            applyAndCheck(iType(opBlez), jumpExp(aluBlez, 1'b1, 1'b0));
            applyAndCheck(iType(opJ), jumpExp(aluJ, 1'b0, 1'b0));
            applyAndCheck(iType(opJal), jumpExp(aluJal, 1'b0, 1'b1));
            applyAndCheck(rType(fnJr, 1'b0, 1'b0), jumpExp(aluJr, 1'b0, 1'b0));
        end
        finishTest("branch/jump");

        startTest();
        repeat (3) begin
            applyAndCheck(special2Word(fnMul), rTypeExp(aluMul, 1'b0));
            applyAndCheck(special3Word(1'b1), rTypeExp(aluSeh, 1'b0));
            applyAndCheck(special3Word(1'b0), rTypeExp(aluSeb, 1'b0));
        end
        finishTest("mul/seh/seb");

        // nop and words nobody claims
        startTest();
        applyAndCheck(32'd0, idleWord());
        repeat (3) begin
            applyAndCheck(iType(6'b010000), idleWord());
            applyAndCheck(rType(6'b111111, 1'b0, 1'b0), idleWord());
            applyAndCheck(regimm(5'b00010), idleWord());
        end
        finishTest("defaults");
    endtask

    initial begin
        instruction = '0;
        lfsrState = 16'd96;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        waitCount = 0;
        while (reset !== 1'b0 && waitCount < 20) begin
            @(posedge clk);
            waitCount++;
        end
        if (reset !== 1'b0) begin
            $display("reset was not released within 20 clock cycles");
            $display("Verification failed");
            $finish;
        end else begin
            runAllTests();
            $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output ctrlWord_t   ctrl
);

    localparam int numDecoders = 5;

    decodeOut_t decoded [numDecoders];

    //////////////////////////////////////////////////
    // one decoder per opcode class
    //////////////////////////////////////////////////
    specialDecoder uSpecial (
        .instruction (instruction),
        .result      (decoded[0])
    );

    extDecoder uExt (
        .instruction (instruction),
        .result      (decoded[1])
    );

    immDecoder uImm (
        .instruction (instruction),
        .result      (decoded[2])
    );

    memAccessDecoder uMemAccess (
        .instruction (instruction),
        .result      (decoded[3])
    );

    branchDecoder uBranch (
        .instruction (instruction),
        .result      (decoded[4])
    );

    // opcode sets are disjoint, at most one hit
    always_comb begin
        ctrl = defaultCtrl;
        for (int i = 0; i < numDecoders; i++) begin
            if (decoded[i].hit) begin
                ctrl = decoded[i].word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== branchDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchDecoder
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output decodeOut_t  result
);

    rInstr_t   fields;
    logic      hit;
    ctrlWord_t word;

    assign fields = rInstr_t'(instruction);

    always_comb begin
        hit  = 1'b1;
        word = defaultCtrl;
        case (fields.opcode)
            //////////////////////////////////////////////////
            // conditional branches
            //////////////////////////////////////////////////
            opRegimm: begin
                // rt field picks the compare against zero
                if (fields.rt == rtBgez) begin
                    word = branchCtrl(aluBgez, 1'b1);
                end else if (fields.rt == rtBltz) begin
                    word = branchCtrl(aluBltz, 1'b1);
                end else begin
                    hit = 1'b0;
                end
            end
            opBeq:  word = branchCtrl(aluBeq, 1'b1);
            opBne:  word = branchCtrl(aluBne, 1'b1);
            opBgtz: word = branchCtrl(aluBgtz, 1'b1);
            opBlez: word = branchCtrl(aluBlez, 1'b1);

            //////////////////////////////////////////////////
            // jumps
            //////////////////////////////////////////////////
            opJ: word = branchCtrl(aluJ, 1'b0);
            opJal: begin
                word = branchCtrl(aluJal, 1'b0);
                // link address goes to the register file
                word.jalSrc   = 1'b0;
                word.regWrite = 1'b1;
                word.memToReg = 1'b1;
            end

            default: begin
                hit  = 1'b0;
                word = defaultCtrl;
            end
        endcase
    end

    assign result.hit  = hit;
    assign result.word = word;

endmodule

`default_nettype wire

// ==== memAccessDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccessDecoder
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output decodeOut_t  result
);

    rInstr_t   fields;
    logic      isLoad;
    logic      isStore;
    memSize_e  size;
    ctrlWord_t word;

    assign fields = rInstr_t'(instruction);

    //////////////////////////////////////////////////
    // access kind and width
    //////////////////////////////////////////////////
    always_comb begin
        isLoad  = 1'b0;
        isStore = 1'b0;
        size    = sizeWord;
        case (fields.opcode)
            opLw: isLoad = 1'b1;
            opLh: begin
                isLoad = 1'b1;
                size   = sizeHalf;
            end
            opLb: begin
                isLoad = 1'b1;
                size   = sizeByte;
            end
            opSw: isStore = 1'b1;
            opSh: begin
                isStore = 1'b1;
                size    = sizeHalf;
            end
            opSb: begin
                isStore = 1'b1;
                size    = sizeByte;
            end
            default: size = sizeWord;
        endcase
    end

    // address is always base plus offset
    always_comb begin
        word = defaultCtrl;
        if (isLoad || isStore) begin
            word.aluSrc   = 1'b1;
            word.aluOp    = aluAdd;
            word.memSize  = size;
            word.memRead  = isLoad;
            word.regWrite = isLoad;
            word.memWrite = isStore;
            // memToReg stays 0 so loads write back memory data
        end
    end

    assign result.hit  = isLoad | isStore;
    assign result.word = word;

endmodule

`default_nettype wire

// ==== immDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module immDecoder
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output decodeOut_t  result
);

    rInstr_t   fields;
    logic      hit;
    aluOp_e    op;
    logic      zeroExt;
    ctrlWord_t word;

    assign fields = rInstr_t'(instruction);

    // pick the alu op and the immediate extension
    always_comb begin
        hit     = 1'b1;
        op      = aluAdd;
        zeroExt = 1'b0;
        case (fields.opcode)
            opAddi:  op = aluAdd;
            opAddiu: op = aluAddu;
            opSlti:  op = aluSlt;
            opSltiu: begin
                op      = aluSltu;
                zeroExt = 1'b1;
            end
            opAndi: begin
                op      = aluAnd;
                zeroExt = 1'b1;
            end
            opOri: begin
                op      = aluOr;
                zeroExt = 1'b1;
            end
            opXori: begin
                op      = aluXor;
                zeroExt = 1'b1;
            end
            opLui:   op = aluLui;
            default: hit = 1'b0;
        endcase
    end

    // immediate into alu, result to rt
    always_comb begin
        word = defaultCtrl;
        if (hit) begin
            word.aluSrc   = 1'b1;
            word.regWrite = 1'b1;
            word.memToReg = 1'b1;
            word.zeroSrc  = zeroExt;
            word.aluOp    = op;
        end
    end

    assign result.hit  = hit;
    assign result.word = word;

endmodule

`default_nettype wire

// ==== extDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module extDecoder
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output decodeOut_t  result
);

    rInstr_t   fields;
    logic      hit;
    ctrlWord_t word;

    assign fields = rInstr_t'(instruction);

    always_comb begin
        hit  = 1'b0;
        word = defaultCtrl;
        case (fields.opcode)
            opSpecial2: begin
                // madd and msub are dropped and only mul is kept
                if (fields.funct == fnMul) begin
                    hit  = 1'b1;
                    word = rTypeCtrl(aluMul, 1'b0);
                end
            end
            opSpecial3: begin
                hit = 1'b1;
                // bit 9 separates seh from seb
                if (instruction[9]) begin
                    word = rTypeCtrl(aluSeh, 1'b0);
                end else begin
                    word = rTypeCtrl(aluSeb, 1'b0);
                end
            end
            default: begin
                hit  = 1'b0;
                word = defaultCtrl;
            end
        endcase
    end

    assign result.hit  = hit;
    assign result.word = word;

endmodule

`default_nettype wire

// ==== specialDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module specialDecoder
    import controlPkg::*;
(
    input  logic [31:0] instruction,
    output decodeOut_t  result
);

    rInstr_t   fields;
    logic      hit;
    ctrlWord_t word;

    assign fields = rInstr_t'(instruction);

    always_comb begin
        hit  = 1'b0;
        word = defaultCtrl;
        if (instruction == '0) begin
            // nop, nothing moves
            hit = 1'b1;
        end else if (fields.opcode == opSpecial) begin
            hit = 1'b1;
            case (fields.funct)
                //////////////////////////////////////////////////
                // shifts and rotates
                //////////////////////////////////////////////////
                fnSll: word = rTypeCtrl(aluSll, 1'b1);
                fnSrl: begin
                    // bit 21 turns srl into rotr
                    if (instruction[21]) begin
                        word = rTypeCtrl(aluRotr, 1'b1);
                    end else begin
                        word = rTypeCtrl(aluSrl, 1'b1);
                    end
                end
                fnSra: word = rTypeCtrl(aluSra, 1'b1);
                fnSllv: word = rTypeCtrl(aluSll, 1'b0);
                fnSrlv: begin
                    // bit 6 turns srlv into rotrv
                    if (instruction[6]) begin
                        word = rTypeCtrl(aluRotr, 1'b0);
                    end else begin
                        word = rTypeCtrl(aluSrl, 1'b0);
                    end
                end
                fnSrav: word = rTypeCtrl(aluSra, 1'b0);

                //////////////////////////////////////////////////
                // arithmetic, logic, compare, moves
                //////////////////////////////////////////////////
                fnAdd:  word = rTypeCtrl(aluAdd, 1'b0);
                fnAddu: word = rTypeCtrl(aluAddu, 1'b0);
                fnSub:  word = rTypeCtrl(aluSub, 1'b0);
                fnAnd:  word = rTypeCtrl(aluAnd, 1'b0);
                fnOr:   word = rTypeCtrl(aluOr, 1'b0);
                fnXor:  word = rTypeCtrl(aluXor, 1'b0);
                fnNor:  word = rTypeCtrl(aluNor, 1'b0);
                fnSlt:  word = rTypeCtrl(aluSlt, 1'b0);
                fnSltu: word = rTypeCtrl(aluSltu, 1'b0);
                fnMovn: word = rTypeCtrl(aluMovn, 1'b0);
                fnMovz: word = rTypeCtrl(aluMovz, 1'b0);

                // jump to rs, no link
                fnJr: word = branchCtrl(aluJr, 1'b0);

                default: begin
                    // hi/lo group and unused functs fall through here
                    hit  = 1'b0;
                    word = defaultCtrl;
                end
            endcase
        end
    end

    assign result.hit  = hit;
    assign result.word = word;

endmodule

`default_nettype wire

// ==== controlPkg.sv ====
`default_nettype none

package controlPkg;

    //////////////////////////////////////////////////
    // instruction fields and opcodes
    //////////////////////////////////////////////////

    typedef logic [4:0] regField_t;

    typedef enum logic [5:0] {
        opSpecial  = 6'b000000,
        opRegimm   = 6'b000001,
        opJ        = 6'b000010,
        opJal      = 6'b000011,
        opBeq      = 6'b000100,
        opBne      = 6'b000101,
        opBlez     = 6'b000110,
        opBgtz     = 6'b000111,
        opAddi     = 6'b001000,
        opAddiu    = 6'b001001,
        opSlti     = 6'b001010,
        opSltiu    = 6'b001011,
        opAndi     = 6'b001100,
        opOri      = 6'b001101,
        opXori     = 6'b001110,
        opLui      = 6'b001111,
        opSpecial2 = 6'b011100,
        opSpecial3 = 6'b011111,
        opLb       = 6'b100000,
        opLh       = 6'b100001,
        opLw       = 6'b100011,
        opSb       = 6'b101000,
        opSh       = 6'b101001,
        opSw       = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnMovz = 6'b001010,
        fnMovn = 6'b001011,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } funct_e;

    // special2 mul shares the srl funct code, so it cannot be a separate enum member
    localparam funct_e fnMul = funct_e'(6'b000010);

    // regimm branch selectors in the rt field
    localparam regField_t rtBltz = 5'b00000;
    localparam regField_t rtBgez = 5'b00001;

    // r-type view of the word, the i-type opcode sits in the same place
    typedef struct packed {
        opcode_e   opcode;
        regField_t rs;
        regField_t rt;
        regField_t rd;
        regField_t shamt;
        funct_e    funct;
    } rInstr_t;

    //////////////////////////////////////////////////
    // control word
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        aluAdd  = 6'b000000, aluSub  = 6'b000001, aluMul  = 6'b000010,
        aluLui  = 6'b000110, aluBgez = 6'b000111, aluBeq  = 6'b001000,
        aluBne  = 6'b001001, aluBgtz = 6'b001010, aluBlez = 6'b001011,
        aluBltz = 6'b001100, aluJ    = 6'b001101, aluJal  = 6'b001110,
        aluAnd  = 6'b001111, aluOr   = 6'b010000, aluNor  = 6'b010001,
        aluXor  = 6'b010010, aluSeh  = 6'b010011, aluSll  = 6'b010100,
        aluSrl  = 6'b010101, aluMovn = 6'b010110, aluMovz = 6'b010111,
        aluRotr = 6'b011000, aluSra  = 6'b011001, aluSeb  = 6'b011010,
        aluSlt  = 6'b011011, aluAddu = 6'b100000, aluSltu = 6'b100010,
        aluJr   = 6'b100011
    } aluOp_e;

    typedef enum logic [1:0] {
        sizeWord = 2'b00,
        sizeHalf = 2'b01,
        sizeByte = 2'b10
    } memSize_e;

    typedef struct packed {
        logic     aluSrc;
        logic     regDst;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;  // 1 writes back the alu result
        logic     aluSft;
        logic     zeroSrc;
        logic     branch;
        logic     jalSrc;    // 0 picks the link address
        logic     jZeroSrc;
        aluOp_e   aluOp;
        memSize_e memSize;
    } ctrlWord_t;

    localparam ctrlWord_t defaultCtrl = '{
        aluSrc: 1'b0, regDst: 1'b0, regWrite: 1'b0, memRead: 1'b0,
        memWrite: 1'b0, memToReg: 1'b0, aluSft: 1'b0, zeroSrc: 1'b0,
        branch: 1'b0, jalSrc: 1'b1, jZeroSrc: 1'b0,
        aluOp: aluAdd, memSize: sizeWord
    };

    typedef struct packed {
        logic      hit;
        ctrlWord_t word;
    } decodeOut_t;

    // register-register op writing rd
    function automatic ctrlWord_t rTypeCtrl(aluOp_e op, logic shamtSrc);
        ctrlWord_t c;
        c = defaultCtrl;
        c.regDst   = 1'b1;
        c.regWrite = 1'b1;
        c.memToReg = 1'b1;
        c.aluSft   = shamtSrc;
        c.aluOp    = op;
        return c;
    endfunction

    // control transfer, conditional or not
    function automatic ctrlWord_t branchCtrl(aluOp_e op, logic conditional);
        ctrlWord_t c;
        c = defaultCtrl;
        c.branch   = 1'b1;
        c.jZeroSrc = conditional;
        c.aluOp    = op;
        return c;
    endfunction

endpackage

`default_nettype wire
